//--- exec_stage.f
+incdir+test
logic/exec_pkg.sv
logic/exec_issue_reg.sv
logic/exec_int_alu.sv
logic/exec_mem_access.sv
logic/exec_branch_unit.sv
logic/exec_stage.sv
test/exec_stage_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the execute stage testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module exec_stage_tb -f exec_stage.f -o exec_stage_sim \
    && ./obj_dir/exec_stage_sim | tee /dev/stderr | grep -q -F "*** TEST PASSED ***" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- test/exec_stage_tests.svh
task automatic after_reset_outputs();
    exec_issue_t ins;
    check_all('0, '0, '0, '0, '0);
    execute_one('0); // zero issue stays idle
    random_instr(op_jal, f3_add_sub, f7_base, ins);
    execute_one(ins);
    issue    = '0;
    reset    = 1'b1;
    mem_wait = 1'b1; // reset outranks the hold
    @(negedge CLK);
    reset    = 1'b0;
    mem_wait = 1'b0;
    check_all('0, '0, '0, '0, '0);
endtask

task automatic integer_ops();
    exec_issue_t ins;
    for (int set = 0; set < 20; set++) begin
        for (int f3 = 0; f3 < 8; f3++) begin
            random_instr(op_reg, f3[2:0], f7_base, ins);
            execute_one(ins);
            random_instr(op_imm, f3[2:0], f7_base, ins);
            if (f3 == 1 || f3 == 5) begin
                ins.imm[11:5] = f7_base; // shamt form
            end else begin
                ins.funct7 = ins.imm[11:5];
            end
            execute_one(ins);
        end
        random_instr(op_reg, f3_add_sub, f7_alt, ins);
        execute_one(ins);
        random_instr(op_reg, f3_srl_sra, f7_alt, ins);
        execute_one(ins);
        random_instr(op_imm, f3_srl_sra, f7_alt, ins);
        ins.imm[11:5] = f7_alt; // srai
        execute_one(ins);
        random_instr(op_lui, f3_add_sub, f7_base, ins);
        execute_one(ins);
        random_instr(op_auipc, f3_add_sub, f7_base, ins);
        execute_one(ins);
        random_instr(op_jal, f3_add_sub, f7_base, ins);
        execute_one(ins);
        random_instr(op_jalr, f3_add_sub, f7_base, ins);
        execute_one(ins);
    end
endtask

task automatic load_store_ops();
    exec_issue_t ins;
    logic [2:0]  sizes [5];
    sizes = '{f3_byte, f3_half, f3_word, f3_byte_u, f3_half_u};
    for (int rep = 0; rep < 8; rep++) begin
        for (int k = 0; k < 5; k++) begin
            random_instr(op_load, sizes[k], f7_base, ins);
            execute_one(ins);
        end
        for (int k = 0; k < 3; k++) begin
            random_instr(op_store, sizes[k], f7_base, ins);
            execute_one(ins);
        end
    end
endtask

task automatic branch_jump_ops();
    exec_issue_t ins;
    logic [31:0] x;
    logic [31:0] lhs [5];
    logic [31:0] rhs [5];
    logic [2:0]  conds [6];
    conds = '{f3_beq, f3_bne, f3_blt, f3_bge, f3_bltu, f3_bgeu};
    for (int rep = 0; rep < 3; rep++) begin
        rand_bits(30, x); // small enough that x + 1 stays positive
        lhs = '{x, x, x | 32'h8000_0000, x, x + 32'd1};
        rhs = '{x, x | 32'h8000_0000, x, x + 32'd1, x};
        for (int c = 0; c < 6; c++) begin
            for (int p = 0; p < 5; p++) begin
                random_instr(op_branch, conds[c], f7_base, ins);
                ins.rs1_data = lhs[p];
                ins.rs2_data = rhs[p];
                execute_one(ins);
            end
        end
        random_instr(op_jal, f3_add_sub, f7_base, ins);
        ins.imm[0] = 1'b1; // odd target, bit 0 must drop
        execute_one(ins);
        random_instr(op_jalr, f3_add_sub, f7_base, ins);
        ins.rs1_data[0] = 1'b0;
        ins.imm[0]      = 1'b1;
        execute_one(ins);
    end
endtask

task automatic mem_wait_hold();
    exec_issue_t first;
    exec_issue_t other;
    reg_write_t  rw;
    mem_read_t   mr;
    mem_write_t  mw;
    jump_t       j;
    random_instr(op_load, f3_word, f7_base, first);
    execute_one(first);
    predict(first, rw, mr, mw, j);
    mem_wait = 1'b1;
    for (int c = 0; c < 3; c++) begin
        random_instr(op_reg, f3_add_sub, f7_base, other);
        issue = other;
        @(negedge CLK);
        check_all(first.pc, rw, mr, mw, j);
    end
    mem_wait = 1'b0;
    execute_one(other);
endtask

task automatic stall_flush_bubble();
    exec_issue_t ins;
    random_instr(op_reg, f3_xor, f7_base, ins);
    execute_one(ins);
    random_instr(op_jal, f3_add_sub, f7_base, ins);
    issue = ins;
    stall = 1'b1;
    @(negedge CLK);
    stall = 1'b0;
    check_all('0, '0, '0, '0, '0);
    execute_one(ins);
    random_instr(op_store, f3_word, f7_base, ins);
    issue = ins;
    flush = 1'b1;
    @(negedge CLK);
    flush = 1'b0;
    check_all('0, '0, '0, '0, '0);
    execute_one(ins);
endtask

//--- test/exec_stage_tb.sv
module exec_stage_tb;
    import exec_pkg::*;

    localparam int num_tests    = 6;
    localparam int ops_per_test = 500; // integer test is the longest
    localparam int half_period  = 10;

    logic            CLK;
    logic            reset;
    logic            flush;
    logic            stall;
    logic            mem_wait;
    exec_issue_t     issue;
    logic [xlen-1:0] exec_pc;
    reg_write_t      reg_write;
    mem_read_t       mem_read;
    mem_write_t      mem_write;
    jump_t           jump;

    logic [31:0] lfsr_state;
    int          checks;
    int          errors;

    exec_stage u_dut (
        .CLK       (CLK),
        .reset     (reset),
        .flush     (flush),
        .stall     (stall),
        .mem_wait  (mem_wait),
        .issue     (issue),
        .exec_pc   (exec_pc),
        .reg_write (reg_write),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .jump      (jump)
    );

    always #half_period CLK = ~CLK;

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
    endtask

    task automatic random_instr(input logic [6:0] opcode, input logic [2:0] funct3,
                                input logic [6:0] funct7, output exec_issue_t ins);
        logic [31:0] v;
        ins        = '0;
        ins.opcode = opcode;
        ins.funct3 = funct3;
        ins.funct7 = funct7;
        rand_bits(30, v);
        ins.pc = {v[29:0], 2'b00}; // word aligned
        rand_bits(5, v);
        ins.rd = v[4:0];
        rand_bits(5, v);
        ins.rs1 = v[4:0];
        rand_bits(32, v);
        ins.rs1_data = v;
        rand_bits(32, v);
        ins.rs2_data = v;
        rand_bits(32, v);
        ins.imm = v;
    endtask

    // reference model of the RV32I execute rules
    task automatic predict(input exec_issue_t ins, output reg_write_t rw, output mem_read_t mr,
                           output mem_write_t mw, output jump_t j);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] i_imm;
        logic [31:0] opb;
        logic [31:0] upper;
        logic [31:0] addr;
        logic [31:0] alu;
        logic [3:0]  strb;
        logic        alt;
        logic        take;
        rw    = '0;
        mr    = '0;
        mw    = '0;
        j     = '0;
        a     = ins.rs1_data;
        b     = ins.rs2_data;
        i_imm = {{20{ins.imm[11]}}, ins.imm[11:0]};
        opb   = (ins.opcode == op_imm) ? i_imm : b;
        upper = {ins.imm[31:12], 12'h000};
        addr  = a + i_imm;
        alt   = (ins.funct7 == f7_alt);
        case (ins.funct3)
            f3_add_sub: alu = (alt && ins.opcode == op_reg) ? a - opb : a + opb;
            f3_sll:     alu = a << opb[4:0];
            f3_slt:     alu = {31'd0, $signed(a) < $signed(opb)};
            f3_sltu:    alu = {31'd0, a < opb};
            f3_xor:     alu = a ^ opb;
            f3_srl_sra: begin
                if (alt) begin
                    alu = $signed(a) >>> opb[4:0];
                end else begin
                    alu = a >> opb[4:0];
                end
            end
            f3_or:      alu = a | opb;
            default:    alu = a & opb;
        endcase
        case (ins.funct3)
            f3_beq:  take = (a == b);
            f3_bne:  take = (a != b);
            f3_blt:  take = ($signed(a) < $signed(b));
            f3_bge:  take = ($signed(a) >= $signed(b));
            f3_bltu: take = (a < b);
            default: take = (a >= b);
        endcase
        case (ins.funct3)
            f3_byte, f3_byte_u: strb = strb_byte;
            f3_half, f3_half_u: strb = strb_half;
            default:            strb = strb_word;
        endcase
        case (ins.opcode)
            op_reg, op_imm: rw = '{1'b1, ins.rd, alu};
            op_lui:         rw = '{1'b1, ins.rd, upper};
            op_auipc:       rw = '{1'b1, ins.rd, ins.pc + upper};
            op_jal: begin
                rw = '{1'b1, ins.rd, ins.pc + 32'd4};
                j  = '{1'b1, (ins.pc + ins.imm) & ~32'd1};
            end
            op_jalr: begin
                rw = '{1'b1, ins.rd, ins.pc + 32'd4};
                j  = '{1'b1, (a + i_imm) & ~32'd1};
            end
            op_branch: j = '{take, ins.pc + {{19{ins.imm[12]}}, ins.imm[12:1], 1'b0}};
            op_load: begin
                mr = '{1'b1, ins.rd, addr, strb, ins.funct3 == f3_byte || ins.funct3 == f3_half};
            end
            op_store: mw = '{1'b1, addr, strb, b};
            default: ;
        endcase
    endtask

    task automatic check_reg_write(input reg_write_t exp);
        checks++;
        if (reg_write !== exp) begin
            errors++;
            $display("mismatch reg_write at %0t: expected %h, got %h", $time, exp, reg_write);
        end
    endtask

    task automatic check_mem_read(input mem_read_t exp);
        checks++;
        if (mem_read !== exp) begin
            errors++;
            $display("mismatch mem_read at %0t: expected %h, got %h", $time, exp, mem_read);
        end
    endtask

    task automatic check_mem_write(input mem_write_t exp);
        checks++;
        if (mem_write !== exp) begin
            errors++;
            $display("mismatch mem_write at %0t: expected %h, got %h", $time, exp, mem_write);
        end
    endtask

    task automatic check_jump(input jump_t exp);
        checks++;
        if (jump !== exp) begin
            errors++;
            $display("mismatch jump at %0t: expected %h, got %h", $time, exp, jump);
        end
    endtask

    task automatic check_pc(input logic [xlen-1:0] exp);
        checks++;
        if (exec_pc !== exp) begin
            errors++;
            $display("mismatch exec_pc at %0t: expected %h, got %h", $time, exp, exec_pc);
        end
    endtask

    task automatic check_all(input logic [xlen-1:0] pc, input reg_write_t rw,
                             input mem_read_t mr, input mem_write_t mw, input jump_t j);
        check_pc(pc);
        check_reg_write(rw);
        check_mem_read(mr);
        check_mem_write(mw);
        check_jump(j);
    endtask

    // called at a falling edge, checks at the next one
    task automatic execute_one(input exec_issue_t ins);
        reg_write_t rw;
        mem_read_t  mr;
        mem_write_t mw;
        jump_t      j;
        issue = ins;
        @(negedge CLK);
        predict(ins, rw, mr, mw, j);
        check_all(ins.pc, rw, mr, mw, j);
    endtask

    `include "exec_stage_tests.svh"

    initial begin
        CLK        = 1'b0;
        reset      = 1'b1;
        flush      = 1'b0;
        stall      = 1'b0;
        mem_wait   = 1'b0;
        issue      = '0;
        lfsr_state = 32'h68df;
        checks     = 0;
        errors     = 0;
        repeat (5) @(negedge CLK);
        reset = 1'b0;
        after_reset_outputs();
        integer_ops();
        load_store_ops();
        branch_jump_ops();
        mem_wait_hold();
        stall_flush_bubble();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        repeat (num_tests * ops_per_test * 4 + 50) @(posedge CLK);
        $display("timeout: the tests did not finish in time, %0d errors so far", errors);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

//--- logic/exec_stage.sv
module exec_stage (
    input  logic                          CLK,
    input  logic                          reset,
    input  logic                          flush,
    input  logic                          stall,
    input  logic                          mem_wait,
    input  exec_pkg::exec_issue_t         issue,
    output logic [exec_pkg::xlen-1:0]     exec_pc,
    output exec_pkg::reg_write_t          reg_write,
    output exec_pkg::mem_read_t           mem_read,
    output exec_pkg::mem_write_t          mem_write,
    output exec_pkg::jump_t               jump
);
    import exec_pkg::*;

    exec_issue_t cur; // instruction in execute

    exec_issue_reg u_issue_reg (
        .CLK      (CLK),
        .reset    (reset),
        .flush    (flush),
        .stall    (stall),
        .mem_wait (mem_wait),
        .issue    (issue),
        .cur      (cur)
    );

    exec_int_alu u_int_alu (
        .cur       (cur),
        .reg_write (reg_write)
    );

    exec_mem_access u_mem_access (
        .cur       (cur),
        .mem_read  (mem_read),
        .mem_write (mem_write)
    );

    exec_branch_unit u_branch_unit (
        .cur  (cur),
        .jump (jump)
    );

    assign exec_pc = cur.pc;

endmodule

//--- logic/exec_branch_unit.sv
module exec_branch_unit (
    input  exec_pkg::exec_issue_t cur,
    output exec_pkg::jump_t       jump
);
    import exec_pkg::*;

    logic cond;
    logic cond_ok;

    always_comb begin
        cond_ok = 1'b1;
        case (cur.funct3)
            f3_beq:  cond = (cur.rs1_data == cur.rs2_data);
            f3_bne:  cond = (cur.rs1_data != cur.rs2_data);
            f3_blt:  cond = ($signed(cur.rs1_data) < $signed(cur.rs2_data));
            f3_bge:  cond = ($signed(cur.rs1_data) >= $signed(cur.rs2_data));
            f3_bltu: cond = (cur.rs1_data < cur.rs2_data);
            f3_bgeu: cond = (cur.rs1_data >= cur.rs2_data);
            default: begin
                cond    = 1'b0;
                cond_ok = 1'b0;
            end
        endcase
    end

    always_comb begin
        jump = '0;
        case (cur.opcode)
            op_branch: begin
                if (cond_ok) begin
                    jump.take   = cond;
                    jump.target = cur.pc + branch_offset(cur.imm);
                end
            end
            op_jal: begin
                jump.take   = 1'b1;
                jump.target = (cur.pc + cur.imm) & ~32'b1; // full decoder imm
            end
            op_jalr: begin
                jump.take   = 1'b1;
                jump.target = (cur.rs1_data + sext12(cur.imm)) & ~32'b1;
            end
            default: begin
                jump = '0;
            end
        endcase
    end

endmodule

//--- logic/exec_mem_access.sv
module exec_mem_access (
    input  exec_pkg::exec_issue_t cur,
    output exec_pkg::mem_read_t   mem_read,
    output exec_pkg::mem_write_t  mem_write
);
    import exec_pkg::*;

    logic [xlen-1:0]   eff_addr;
    logic [strb_w-1:0] size_strb;
    logic              size_ok;
    logic              load_signed;

    assign eff_addr = cur.rs1_data + sext12(cur.imm);

    always_comb begin
        size_ok     = 1'b1;
        load_signed = 1'b0;
        case (cur.funct3)
            f3_byte: begin
                size_strb   = strb_byte;
                load_signed = 1'b1;
            end
            f3_half: begin
                size_strb   = strb_half;
                load_signed = 1'b1;
            end
            f3_word:   size_strb = strb_word;
            f3_byte_u: size_strb = strb_byte;
            f3_half_u: size_strb = strb_half;
            default: begin
                size_strb = '0;
                size_ok   = 1'b0;
            end
        endcase
    end

    always_comb begin
        mem_read = '0;
        if (cur.opcode == op_load && size_ok) begin
            mem_read.en        = 1'b1;
            mem_read.rd        = cur.rd;
            mem_read.addr      = eff_addr;
            mem_read.strb      = size_strb;
            mem_read.is_signed = load_signed;
        end
    end

    // stores have no unsigned variants
    always_comb begin
        mem_write = '0;
        if (cur.opcode == op_store && size_ok && !cur.funct3[2]) begin
            mem_write.en   = 1'b1;
            mem_write.addr = eff_addr;
            mem_write.strb = size_strb;
            mem_write.data = cur.rs2_data;
        end
    end

endmodule

//--- logic/exec_int_alu.sv
module exec_int_alu (
    input  exec_pkg::exec_issue_t cur,
    output exec_pkg::reg_write_t  reg_write
);
    import exec_pkg::*;

    logic            is_reg;
    logic            is_imm;
    logic            f7_ok;
    logic            use_alt;
    logic [xlen-1:0] opnd_b;
    logic [4:0]      shamt;
    logic [xlen-1:0] upper_imm;
    logic [xlen-1:0] alu_res;

    assign is_reg    = (cur.opcode == op_reg);
    assign is_imm    = (cur.opcode == op_imm);
    assign use_alt   = (cur.funct7 == f7_alt);
    assign opnd_b    = is_imm ? sext12(cur.imm) : cur.rs2_data;
    assign shamt     = is_imm ? cur.imm[4:0] : cur.rs2_data[4:0];
    assign upper_imm = {cur.imm[xlen-1:12], 12'b0};

    // legal funct7 encodings per form
    always_comb begin
        if (is_imm) begin
            case (cur.funct3)
                f3_sll:     f7_ok = (cur.funct7 == f7_base);
                f3_srl_sra: f7_ok = (cur.funct7 == f7_base) || use_alt;
                default:    f7_ok = 1'b1; // funct7 is part of the immediate
            endcase
        end else begin
            case (cur.funct3)
                f3_add_sub,
                f3_srl_sra: f7_ok = (cur.funct7 == f7_base) || use_alt;
                default:    f7_ok = (cur.funct7 == f7_base);
            endcase
        end
    end

    always_comb begin
        case (cur.funct3)
            f3_add_sub: begin
                if (is_reg && use_alt) begin
                    alu_res = cur.rs1_data - opnd_b;
                end else begin
                    alu_res = cur.rs1_data + opnd_b;
                end
            end
            f3_sll:  alu_res = cur.rs1_data << shamt;
            f3_slt:  alu_res = {{(xlen-1){1'b0}}, $signed(cur.rs1_data) < $signed(opnd_b)};
            f3_sltu: alu_res = {{(xlen-1){1'b0}}, cur.rs1_data < opnd_b};
            f3_xor:  alu_res = cur.rs1_data ^ opnd_b;
            f3_srl_sra: begin
                if (use_alt) begin
                    alu_res = $unsigned($signed(cur.rs1_data) >>> shamt);
                end else begin
                    alu_res = cur.rs1_data >> shamt;
                end
            end
            f3_or:   alu_res = cur.rs1_data | opnd_b;
            default: alu_res = cur.rs1_data & opnd_b; // f3_and
        endcase
    end

    always_comb begin
        reg_write = '0;
        case (cur.opcode)
            op_reg, op_imm: begin
                if (f7_ok) begin
                    reg_write.en   = 1'b1;
                    reg_write.rd   = cur.rd;
                    reg_write.data = alu_res;
                end
            end
            op_lui: begin
                reg_write.en   = 1'b1;
                reg_write.rd   = cur.rd;
                reg_write.data = upper_imm;
            end
            op_auipc: begin
                reg_write.en   = 1'b1;
                reg_write.rd   = cur.rd;
                reg_write.data = cur.pc + upper_imm;
            end
            op_jal, op_jalr: begin
                reg_write.en   = 1'b1;
                reg_write.rd   = cur.rd;
                reg_write.data = cur.pc + 32'd4; // link address
            end
            default: begin
                reg_write = '0;
            end
        endcase
    end

endmodule

//--- logic/exec_issue_reg.sv
module exec_issue_reg (
    input  logic                  CLK,
    input  logic                  reset,
    input  logic                  flush,
    input  logic                  stall,
    input  logic                  mem_wait,
    input  exec_pkg::exec_issue_t issue,
    output exec_pkg::exec_issue_t cur
);
    import exec_pkg::*;

    exec_issue_t next_cur;

    // stall drops a bubble into the stage, mem_wait freezes it
    always_comb begin
        if (stall) begin
            next_cur = '0;
        end else begin
            next_cur = issue;
        end
    end

    always_ff @(posedge CLK) begin
        if (reset || flush) begin
            cur <= '0; // zero opcode decodes as nothing
        end else if (!mem_wait) begin
            cur <= next_cur;
        end
    end

endmodule

//--- logic/exec_pkg.sv
package exec_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int strb_w     = 4;

    // major opcodes
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;

    // integer ops
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    // branch conditions
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    // load/store sizes
    localparam logic [2:0] f3_byte   = 3'b000;
    localparam logic [2:0] f3_half   = 3'b001;
    localparam logic [2:0] f3_word   = 3'b010;
    localparam logic [2:0] f3_byte_u = 3'b100;
    localparam logic [2:0] f3_half_u = 3'b101;

    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt  = 7'b0100000; // sub, sra

    localparam logic [strb_w-1:0] strb_byte = 4'b0001;
    localparam logic [strb_w-1:0] strb_half = 4'b0011;
    localparam logic [strb_w-1:0] strb_word = 4'b1111;

    typedef struct packed {
        logic [xlen-1:0]       pc;
        logic [6:0]            opcode;
        logic [2:0]            funct3;
        logic [6:0]            funct7;
        logic [reg_addr_w-1:0] rd;
        logic [reg_addr_w-1:0] rs1;
        logic [xlen-1:0]       rs1_data;
        logic [xlen-1:0]       rs2_data;
        logic [xlen-1:0]       imm; // sign-extended by decoder
    } exec_issue_t;

    typedef struct packed {
        logic                  en;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       data;
    } reg_write_t;

    typedef struct packed {
        logic                  en;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       addr;
        logic [strb_w-1:0]     strb;
        logic                  is_signed;
    } mem_read_t;

    typedef struct packed {
        logic              en;
        logic [xlen-1:0]   addr;
        logic [strb_w-1:0] strb;
        logic [xlen-1:0]   data;
    } mem_write_t;

    typedef struct packed {
        logic            take;
        logic [xlen-1:0] target;
    } jump_t;

    function automatic logic [xlen-1:0] sext12(input logic [xlen-1:0] imm);
        return {{(xlen-12){imm[11]}}, imm[11:0]};
    endfunction

    function automatic logic [xlen-1:0] branch_offset(input logic [xlen-1:0] imm);
        return {{(xlen-13){imm[12]}}, imm[12:1], 1'b0};
    endfunction

endpackage
